// File: mpi_ahb_node.f
rtl/mpi_pkg.sv
rtl/mpi_fifo.sv
rtl/mpi_tx_packetizer.sv
rtl/mpi_rx_buffer.sv
rtl/mpi_ahb_bridge.sv
rtl/mpi_regs.sv
rtl/mpi_ahb_node.sv
tests/mpi_tb_clock.sv
tests/mpi_ahb_node_assert.sv
tests/mpi_ahb_node_tb.sv

// File: rtl/mpi_ahb_bridge.sv
////////////////////
// AHB-Lite slave bridge
// Tracks address and data phases, inserts wait states
////////////////////

`timescale 1ns/10ps

module mpi_ahb_bridge (
  input  logic              clk,
  input  logic              rst_n,

  // AHB-Lite side
  input  logic              hsel,
  input  logic [5:0]        haddr,
  input  logic [1:0]        htrans,
  input  logic              hwrite,
  input  logic [31:0]       hwdata,
  output logic [31:0]       hrdata,
  output logic              hready,

  // Register block side
  output mpi_pkg::bus_req_t req,
  input  mpi_pkg::bus_rsp_t rsp
);

  // Only NONSEQ starts a transfer, no bursts
  localparam logic [1:0] htrans_nonseq = 2'b10;

  // Data phase in progress
  logic               pend_q;
  // Captured address phase
  mpi_pkg::reg_addr_e addr_q;
  logic               we_q;

  logic               start;

  ////////////////////
  // Address phase
  ////////////////////

  // Valid address phase this cycle
  assign start = hsel & (htrans == htrans_nonseq);

  // Pending phase only advances while hready is high
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pend_q <= 1'b0;
    end else if (hready) begin
      pend_q <= start;
    end
  end

  // Address and direction, no reset needed
  always_ff @(posedge clk) begin
    if (hready && start) begin
      // Word address from bits 5..2
      addr_q <= mpi_pkg::reg_addr_e'(haddr[5:2]);
      we_q   <= hwrite;
    end
  end

  ////////////////////
  // Data phase
  ////////////////////

  // Request held until the register block acks
  always_comb begin
    req       = '0;
    req.addr  = addr_q;
    req.we    = we_q;
    req.en    = pend_q;
    // Write data arrives in the data phase
    req.wdata = hwdata;
  end

  // Wait states while a request is not yet acked
  assign hready = ~pend_q | rsp.ack;

  // Read data straight from the register block
  assign hrdata = rsp.rdata;

endmodule

// File: rtl/mpi_ahb_node.sv
////////////////////
// Message passing NoC endpoint with AHB-Lite slave port
////////////////////

`timescale 1ns/10ps

module mpi_ahb_node #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic           clk,
  input  logic           rst_n,

  // AHB-Lite slave
  input  logic           hsel,
  input  logic [5:0]     haddr,
  input  logic [1:0]     htrans,
  input  logic           hwrite,
  input  logic [31:0]    hwdata,
  output logic [31:0]    hrdata,
  output logic           hready,

  // NoC out
  output mpi_pkg::flit_t noc_out_flit,
  output logic           noc_out_valid,
  input  logic           noc_out_ready,

  // NoC in
  input  mpi_pkg::flit_t noc_in_flit,
  input  logic           noc_in_valid,
  output logic           noc_in_ready,

  output logic           irq
);

  // Bridge to register block
  mpi_pkg::bus_req_t bus_req;
  mpi_pkg::bus_rsp_t bus_rsp;

  // Transmit path
  logic        tx_push;
  logic        tx_last;
  logic [31:0] tx_word;
  logic        tx_full;

  // Receive path
  logic        rx_pop;
  logic [31:0] rx_word;
  logic [7:0]  rx_words;
  logic [7:0]  rx_msgs;

  mpi_ahb_bridge bridge_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .hsel   (hsel),
    .haddr  (haddr),
    .htrans (htrans),
    .hwrite (hwrite),
    .hwdata (hwdata),
    .hrdata (hrdata),
    .hready (hready),
    .req    (bus_req),
    .rsp    (bus_rsp)
  );

  mpi_regs regs_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (bus_req),
    .rsp      (bus_rsp),
    .tx_push  (tx_push),
    .tx_last  (tx_last),
    .tx_word  (tx_word),
    .tx_full  (tx_full),
    .rx_pop   (rx_pop),
    .rx_word  (rx_word),
    .rx_words (rx_words),
    .rx_msgs  (rx_msgs),
    .irq      (irq)
  );

  mpi_tx_packetizer #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) tx_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .tx_push       (tx_push),
    .tx_last       (tx_last),
    .tx_word       (tx_word),
    .tx_full       (tx_full),
    .noc_out_flit  (noc_out_flit),
    .noc_out_valid (noc_out_valid),
    .noc_out_ready (noc_out_ready)
  );

  mpi_rx_buffer #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) rx_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .noc_in_flit  (noc_in_flit),
    .noc_in_valid (noc_in_valid),
    .noc_in_ready (noc_in_ready),
    .rx_pop       (rx_pop),
    .rx_word      (rx_word),
    .rx_words     (rx_words),
    .rx_msgs      (rx_msgs)
  );

endmodule

// File: rtl/mpi_fifo.sv
////////////////////
// Flit FIFO, first word fall through
////////////////////

`timescale 1ns/10ps

module mpi_fifo #(
  parameter int DEPTH = 16
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       push,
  input  mpi_pkg::flit_t             push_data,
  input  logic                       pop,
  output mpi_pkg::flit_t             pop_data,
  output logic                       full,
  output logic                       empty,
  output logic [$clog2(DEPTH+1)-1:0] count
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH+1);

  mpi_pkg::flit_t mem [DEPTH];
  logic [AW-1:0]  wr_ptr;
  logic [AW-1:0]  rd_ptr;
  logic           do_push;
  logic           do_pop;

  // Wrap at DEPTH, works for any depth
  function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] p);
    return (p == AW'(DEPTH-1)) ? '0 : p + 1'b1;
  endfunction

  // Overflow and underflow requests ignored
  assign do_push  = push & ~full;
  assign do_pop   = pop & ~empty;
  assign full     = (count == CW'(DEPTH));
  assign empty    = (count == '0);
  // Head entry visible without a pop
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= ptr_next(wr_ptr);
      if (do_pop)  rd_ptr <= ptr_next(rd_ptr);
      // Push and pop together leave the count alone
      if (do_push && !do_pop)      count <= count + 1'b1;
      else if (do_pop && !do_push) count <= count - 1'b1;
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= push_data;
  end

endmodule

// File: rtl/mpi_pkg.sv
////////////////////
// Message passing endpoint shared types
// Flit format, register map and internal bus structs
////////////////////

package mpi_pkg;

  ////////////////////
  // NoC flit format
  ////////////////////

  // Bit 1 marks the end of a message, bit 0 its start
  typedef enum logic [1:0] {
    payload = 2'b00,
    head    = 2'b01,
    last    = 2'b10,
    single  = 2'b11
  } flit_type_e;

  // 34-bit flit with type on top
  typedef struct packed {
    flit_type_e  ftype;
    logic [31:0] data;
  } flit_t;

  ////////////////////
  // Register map
  ////////////////////

  // Word addresses from haddr[5:2]
  typedef enum logic [3:0] {
    tx_data   = 4'h0,
    tx_end    = 4'h1,
    rx_data   = 4'h2,
    rx_status = 4'h3,
    ctrl      = 4'h4
  } reg_addr_e;

  // Data-phase request from the AHB bridge
  typedef struct packed {
    reg_addr_e   addr;
    logic        we;
    logic        en;
    logic [31:0] wdata;
  } bus_req_t;

  // Response back to the bridge
  typedef struct packed {
    logic [31:0] rdata;
    logic        ack;
  } bus_rsp_t;

endpackage

// File: rtl/mpi_regs.sv
////////////////////
// Endpoint register block
// Decode, ctrl register, status and interrupt
////////////////////

`timescale 1ns/10ps

module mpi_regs (
  input  logic              clk,
  input  logic              rst_n,

  // Bus request from bridge
  input  mpi_pkg::bus_req_t req,
  output mpi_pkg::bus_rsp_t rsp,

  // Transmit path
  output logic              tx_push,
  output logic              tx_last,
  output logic [31:0]       tx_word,
  input  logic              tx_full,

  // Receive path
  output logic              rx_pop,
  input  logic [31:0]       rx_word,
  input  logic [7:0]        rx_words,
  input  logic [7:0]        rx_msgs,

  output logic              irq
);

  // Ctrl bit 0
  logic        irq_en_q;
  logic        irq_q;
  logic        rx_avail;
  logic        rx_has_word;
  logic        wr;
  logic        rd;
  logic [31:0] status;

  assign wr          = req.en & req.we;
  assign rd          = req.en & ~req.we;
  assign rx_avail    = (rx_msgs != 8'd0);
  assign rx_has_word = (rx_words != 8'd0);

  // Status word: tx full, word count, message count, available
  assign status = {7'b0, tx_full, rx_words, rx_msgs, 7'b0, rx_avail};

  // Write data goes straight to the packetizer
  assign tx_word = req.wdata;

  ////////////////////
  // Decode
  ////////////////////

  always_comb begin
    rsp       = '0;
    rsp.ack   = req.en;
    tx_push   = 1'b0;
    tx_last   = 1'b0;
    rx_pop    = 1'b0;
    case (req.addr)
      mpi_pkg::tx_data, mpi_pkg::tx_end: begin
        // Stall the write until the buffer has room
        if (wr) begin
          rsp.ack = ~tx_full;
          tx_push = ~tx_full;
          tx_last = (req.addr == mpi_pkg::tx_end);
        end
      end
      mpi_pkg::rx_data: begin
        // Empty read returns zero, nothing popped
        rx_pop = rd & rx_has_word;
        if (rx_has_word) begin
          rsp.rdata = rx_word;
        end
      end
      mpi_pkg::rx_status: rsp.rdata = status;
      mpi_pkg::ctrl:      rsp.rdata = {31'b0, irq_en_q};
      default:            rsp.rdata = '0;
    endcase
  end

  ////////////////////
  // Ctrl and irq
  ////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      irq_en_q <= 1'b0;
      irq_q    <= 1'b0;
    end else begin
      if (wr && (req.addr == mpi_pkg::ctrl)) begin
        irq_en_q <= req.wdata[0];
      end
      // One register of delay after the count
      irq_q <= irq_en_q & rx_avail;
    end
  end

  assign irq = irq_q;

endmodule

// File: rtl/mpi_rx_buffer.sv
////////////////////
// Receive buffer
// Stores flits, counts complete messages
////////////////////

`timescale 1ns/10ps

module mpi_rx_buffer #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic           clk,
  input  logic           rst_n,

  // NoC in
  input  mpi_pkg::flit_t noc_in_flit,
  input  logic           noc_in_valid,
  output logic           noc_in_ready,

  // Register block side
  input  logic           rx_pop,
  output logic [31:0]    rx_word,
  output logic [7:0]     rx_words,
  output logic [7:0]     rx_msgs
);

  localparam int CW = $clog2(FIFO_DEPTH+1);

  mpi_pkg::flit_t head_flit;
  logic [CW-1:0]  fifo_count;
  logic           fifo_full;
  logic           fifo_empty;
  logic [CW-1:0]  msg_cnt_q;
  logic           accept;
  logic           take;
  logic           in_end;
  logic           out_end;

  ////////////////////
  // Flit storage
  ////////////////////

  // Ready while there is room
  assign noc_in_ready = ~fifo_full;
  assign accept       = noc_in_valid & noc_in_ready;
  assign take         = rx_pop & ~fifo_empty;

  mpi_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) fifo_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (accept),
    .push_data (noc_in_flit),
    .pop       (take),
    .pop_data  (head_flit),
    .full      (fifo_full),
    .empty     (fifo_empty),
    .count     (fifo_count)
  );

  // Type is dropped toward software
  assign rx_word  = head_flit.data;
  assign rx_words = 8'(fifo_count);

  ////////////////////
  // Message count
  ////////////////////

  // Last or single closes a message
  assign in_end  = accept & ((noc_in_flit.ftype == mpi_pkg::last) |
                             (noc_in_flit.ftype == mpi_pkg::single));
  assign out_end = take & ((head_flit.ftype == mpi_pkg::last) |
                           (head_flit.ftype == mpi_pkg::single));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      msg_cnt_q <= '0;
    end else begin
      case ({in_end, out_end})
        2'b10:   msg_cnt_q <= msg_cnt_q + 1'b1;
        2'b01:   msg_cnt_q <= msg_cnt_q - 1'b1;
        // Both or neither
        default: msg_cnt_q <= msg_cnt_q;
      endcase
    end
  end

  assign rx_msgs = 8'(msg_cnt_q);

endmodule

// File: rtl/mpi_tx_packetizer.sv
////////////////////
// Transmit packetizer
// Store and forward, whole messages only
////////////////////

`timescale 1ns/10ps

module mpi_tx_packetizer #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic           clk,
  input  logic           rst_n,

  // Words from the register block
  input  logic           tx_push,
  input  logic           tx_last,
  input  logic [31:0]    tx_word,
  output logic           tx_full,

  // NoC out
  output mpi_pkg::flit_t noc_out_flit,
  output logic           noc_out_valid,
  input  logic           noc_out_ready
);

  localparam int CW = $clog2(FIFO_DEPTH+1);

  // Position inside the message being written
  typedef enum logic {
    st_start,
    st_body
  } wr_state_e;

  wr_state_e      state_q;
  mpi_pkg::flit_t push_flit;
  logic           fifo_empty;
  logic [CW-1:0]  msg_cnt_q;
  logic           commit;
  logic           send;
  logic           send_end;

  ////////////////////
  // Flit typing
  ////////////////////

  always_comb begin
    push_flit.data = tx_word;
    if (state_q == st_start) begin
      push_flit.ftype = tx_last ? mpi_pkg::single : mpi_pkg::head;
    end else begin
      push_flit.ftype = tx_last ? mpi_pkg::last : mpi_pkg::payload;
    end
  end

  // End word closes the message and the next one starts fresh
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= st_start;
    end else if (tx_push) begin
      state_q <= tx_last ? st_start : st_body;
    end
  end

  mpi_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) fifo_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (tx_push),
    .push_data (push_flit),
    .pop       (send),
    .pop_data  (noc_out_flit),
    .full      (tx_full),
    .empty     (fifo_empty),
    .count     ()
  );

  ////////////////////
  // Committed messages
  ////////////////////

  assign commit   = tx_push & tx_last;
  // Head flit always belongs to the oldest committed message
  assign noc_out_valid = (msg_cnt_q != '0) & ~fifo_empty;
  assign send     = noc_out_valid & noc_out_ready;
  assign send_end = send & ((noc_out_flit.ftype == mpi_pkg::last) |
                            (noc_out_flit.ftype == mpi_pkg::single));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      msg_cnt_q <= '0;
    end else if (commit && !send_end) begin
      msg_cnt_q <= msg_cnt_q + 1'b1;
    end else if (send_end && !commit) begin
      msg_cnt_q <= msg_cnt_q - 1'b1;
    end
  end

endmodule

// File: tests/mpi_ahb_node_assert.sv
////////////////////
// Bound checks on the NoC and AHB handshakes
////////////////////

`timescale 1ns/10ps

module mpi_ahb_node_assert (
  input logic           clk,
  input logic           rst_n,
  input logic           hready,
  input logic           irq,
  input logic           irq_en,
  input mpi_pkg::flit_t noc_out_flit,
  input logic           noc_out_valid,
  input logic           noc_out_ready,
  input mpi_pkg::flit_t noc_in_flit,
  input logic           noc_in_valid,
  input logic           noc_in_ready
);

  // Outgoing flit held until it moves
  out_flit_held : assert property (@(posedge clk) disable iff (!rst_n)
    (noc_out_valid && !noc_out_ready) |=> (noc_out_valid && $stable(noc_out_flit)))
    else $error("noc_out flit changed or dropped before it moved");

  // Same rule on the incoming side
  in_flit_held : assert property (@(posedge clk) disable iff (!rst_n)
    (noc_in_valid && !noc_in_ready) |=> (noc_in_valid && $stable(noc_in_flit)))
    else $error("noc_in flit changed or dropped before it moved");

  // No wait state straight out of reset
  ready_after_reset : assert property (@(posedge clk) !rst_n |=> hready)
    else $error("hready low after reset");

  // irq lags the enable by one register
  irq_needs_enable : assert property (@(posedge clk) disable iff (!rst_n)
    irq |-> $past(irq_en))
    else $error("irq high with the enable bit clear");

endmodule

// File: tests/mpi_ahb_node_tb.sv
////////////////////
// Endpoint testbench
// Random traffic both ways against a queue model
////////////////////

`timescale 1ns/10ps

module mpi_ahb_node_tb;

  // Register addresses
  localparam logic [5:0] a_tx_data = 6'h00;
  localparam logic [5:0] a_tx_end  = 6'h04;
  localparam logic [5:0] a_rx_data = 6'h08;
  localparam logic [5:0] a_status  = 6'h0C;
  localparam logic [5:0] a_ctrl    = 6'h10;
  // Messages over all phases
  localparam int msg_total   = 88;
  localparam int cycle_limit = 60 * msg_total + 2000;

  logic clk, rst_n, hsel, hwrite, hready, irq;
  logic [5:0] haddr;
  logic [1:0] htrans;
  logic [31:0] hwdata, hrdata;
  mpi_pkg::flit_t noc_out_flit, noc_in_flit, exp_flit;
  logic noc_out_valid, noc_out_ready, noc_in_valid, noc_in_ready;

  int seed, rnd, cycles, mismatches, failures, ends_in, ends_out, writes_done, ready_mode;
  // Model queues
  mpi_pkg::flit_t exp_out[$];
  mpi_pkg::flit_t rx_exp[$];

  mpi_tb_clock clock_i (.clk(clk), .rst_n(rst_n));

  mpi_ahb_node #(.FIFO_DEPTH(16)) dut_i (.*);

  bind mpi_ahb_node mpi_ahb_node_assert assert_i (.irq_en(regs_i.irq_en_q), .*);

  task automatic check_val(input string name, input logic [33:0] exp, input logic [33:0] act);
    assert (act === exp) else begin
      $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
      mismatches++;
    end
  endtask

  task automatic finish_run();
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  endtask

  function automatic logic is_end(input mpi_pkg::flit_t f);
    return (f.ftype == mpi_pkg::last) || (f.ftype == mpi_pkg::single);
  endfunction

  // Flit type from position in the message
  function automatic mpi_pkg::flit_type_e pos_type(input int i, input int len);
    if (len == 1) return mpi_pkg::single;
    if (i == 0) return mpi_pkg::head;
    return (i == len - 1) ? mpi_pkg::last : mpi_pkg::payload;
  endfunction

  // Single AHB transfer with the data phase stretched by hready
  task automatic bus_xfer(input logic wr, input logic [5:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata);
    @(negedge clk);
    hsel = 1'b1;
    haddr = addr;
    htrans = 2'b10;
    hwrite = wr;
    @(negedge clk);
    hsel = 1'b0;
    htrans = 2'b00;
    hwdata = wdata;
    @(posedge clk);
    while (!hready) @(posedge clk);
    rdata = hrdata;
  endtask

  task automatic write_reg(input logic [5:0] addr, input logic [31:0] wdata);
    logic [31:0] unused;
    bus_xfer(1'b1, addr, wdata, unused);
  endtask

  task automatic read_reg(input logic [5:0] addr, output logic [31:0] rdata);
    bus_xfer(1'b0, addr, 32'h0, rdata);
  endtask

  task automatic set_ready_mode(input int mode);
    @(posedge clk);
    ready_mode = mode;
  endtask

  // Software side of one outgoing message
  task automatic send_msg(input int len);
    mpi_pkg::flit_t f;
    for (int i = 0; i < len; i++) begin
      f.ftype = pos_type(i, len);
      f.data = $random(seed);
      exp_out.push_back(f);
      write_reg((i == len - 1) ? a_tx_end : a_tx_data, f.data);
      writes_done++;
    end
  endtask

  // One incoming flit with a random gap in front
  task automatic inject_flit(input mpi_pkg::flit_t f);
    int gap;
    gap = $unsigned($random(seed)) % 3;
    rx_exp.push_back(f);
    if (is_end(f)) ends_in++;
    repeat (gap) @(negedge clk);
    @(negedge clk);
    noc_in_flit = f;
    noc_in_valid = 1'b1;
    @(posedge clk);
    // Room for this flit unless 16 words are already stored
    check_val("noc_in_ready", rx_exp.size() <= 16, noc_in_ready);
    while (!noc_in_ready) @(posedge clk);
    @(negedge clk);
    noc_in_valid = 1'b0;
  endtask

  task automatic inject_msg(input int len);
    mpi_pkg::flit_t f;
    for (int i = 0; i < len; i++) begin
      f.ftype = pos_type(i, len);
      f.data = $random(seed);
      inject_flit(f);
    end
  endtask

  task automatic check_status(output logic [31:0] st);
    read_reg(a_status, st);
    check_val("rx_status.avail", ends_in != ends_out, st[0]);
    check_val("rx_status.msgs", ends_in - ends_out, st[15:8]);
    check_val("rx_status.words", rx_exp.size(), st[23:16]);
  endtask

  // Read as many words as the status reports
  task automatic drain_rx();
    logic [31:0] st, word;
    mpi_pkg::flit_t f;
    check_status(st);
    repeat (st[23:16]) begin
      read_reg(a_rx_data, word);
      assert (rx_exp.size() != 0) else begin
        $display("rx_data gave a word at %0t that the model never injected", $time);
        failures++;
      end
      if (rx_exp.size() != 0) begin
        f = rx_exp.pop_front();
        check_val("rx_data", f.data, word);
        if (is_end(f)) ends_out++;
      end
    end
  endtask

  ////////////////////
  // Ready driver, monitor, watchdog
  ////////////////////

  always @(negedge clk) begin
    rnd = (ready_mode == 2) ? $random(seed) : ready_mode;
    noc_out_ready = rnd[0];
  end

  always @(posedge clk) begin
    if (rst_n && noc_out_valid && noc_out_ready) begin
      assert (exp_out.size() != 0) else begin
        $display("unexpected flit on noc_out at %0t with nothing pending", $time);
        failures++;
      end
      if (exp_out.size() != 0) begin
        exp_flit = exp_out.pop_front();
        check_val("noc_out_flit", exp_flit, noc_out_flit);
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("run stopped at the cycle limit of %0d", cycle_limit);
      failures++;
      finish_run();
    end
  end

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    logic [31:0] st, st2, word;
    seed = 32'h0a1319c4;
    {hsel, haddr, htrans, hwrite, hwdata} = '0;
    noc_in_flit = '0;
    noc_in_valid = 1'b0;
    noc_out_ready = 1'b0;
    {cycles, mismatches, failures, ends_in, ends_out, writes_done, ready_mode} = '0;
    @(posedge rst_n);

    // Transmit with random back-pressure
    set_ready_mode(2);
    repeat (40) send_msg(1 + $unsigned($random(seed)) % 5);
    while (exp_out.size() != 0) @(posedge clk);
    // Ready held high for the receive phases
    set_ready_mode(1);

    // Receive with a drain after every second message
    for (int m = 0; m < 40; m++) begin
      inject_msg(1 + $unsigned($random(seed)) % 5);
      if (m % 2 == 1) drain_rx();
    end

    // Partial message stays invisible
    inject_flit('{mpi_pkg::head, $random(seed)});
    inject_flit('{mpi_pkg::payload, $random(seed)});
    check_status(st);
    inject_flit('{mpi_pkg::last, $random(seed)});
    check_status(st);
    drain_rx();

    // Interrupt enabled, then disabled
    write_reg(a_ctrl, 32'h1);
    read_reg(a_ctrl, word);
    check_val("ctrl", 1, word);
    inject_msg(2);
    repeat (2) @(negedge clk);
    check_val("irq", 1, irq);
    drain_rx();
    repeat (2) @(negedge clk);
    check_val("irq", 0, irq);
    write_reg(a_ctrl, 32'h0);
    inject_msg(3);
    repeat (3) @(negedge clk);
    check_val("irq", 0, irq);
    drain_rx();

    // Back-pressure stalls the 17th write until ready returns
    set_ready_mode(0);
    writes_done = 0;
    fork
      repeat (5) send_msg(4);
      begin
        repeat (60) @(negedge clk);
        check_val("writes_done", 16, writes_done);
        check_val("hready", 0, hready);
        set_ready_mode(1);
      end
    join
    while (exp_out.size() != 0) @(posedge clk);

    // Empty read
    check_status(st);
    read_reg(a_rx_data, word);
    check_val("rx_data", 0, word);
    check_status(st2);
    check_val("rx_status", st, st2);

    assert (exp_out.size() == 0 && rx_exp.size() == 0) else begin
      $display("model queues not empty at the end of the run");
      failures++;
    end
    finish_run();
  end

endmodule

// File: tests/mpi_tb_clock.sv
////////////////////
// Testbench clock and reset, 20 ns period
////////////////////

`timescale 1ns/10ps

module mpi_tb_clock (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Reset low for 8 cycles, released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule
